//--- hw/switch_pkg.sv
package switch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes and widths
    //////////////////////////////////////////////////////////////////////

    localparam int number_of_ports           = 4;
    localparam int port_index_width          = 2;
    localparam int mac_width                 = 48;
    // Byte plus last-byte flag in the top bit
    localparam int port_data_width           = 9;
    localparam int receive_que_slots         = 64;
    localparam int receive_que_address_width = $clog2(receive_que_slots);
    // Destination and source MAC
    localparam int header_bytes              = 12;

    localparam logic [mac_width-1:0] broadcast_mac = '1;

    //////////////////////////////////////////////////////////////////////
    // Orchestrator FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_learn,
        st_lookup,
        st_decide,
        st_send_header,
        st_send_payload,
        st_drain
    } orchestrator_state_t;

endpackage

//--- hw/rmii_port.sv
module rmii_port (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [1:0]                              rmii_receive_data,
    input  logic                                    rmii_receive_data_enable,
    input  logic                                    receive_data_enable,
    input  logic [switch_pkg::port_data_width-1:0]  transmit_data,
    input  logic                                    transmit_data_enable,

    output logic [switch_pkg::port_data_width-1:0]  receive_data,
    output logic                                    receive_data_valid,
    output logic                                    transmit_ready,
    output logic [1:0]                              rmii_transmit_data,
    output logic                                    rmii_transmit_data_valid
);

//////////////////////////////////////////////////////////////////////
// Receive packer and queue
//////////////////////////////////////////////////////////////////////

logic [7:0]                                     receive_shift;
logic [1:0]                                     receive_dibit_count;
logic                                           byte_complete;
logic [switch_pkg::port_data_width-1:0]         receive_que [switch_pkg::receive_que_slots];
logic [switch_pkg::receive_que_address_width:0] write_pointer;
logic [switch_pkg::receive_que_address_width:0] read_pointer;

always_ff @(posedge clock) begin
    if (reset) begin
        receive_dibit_count <= '0;
        byte_complete       <= 1'b0;
        write_pointer       <= '0;
        read_pointer        <= '0;
    end else begin
        if (rmii_receive_data_enable) begin
            receive_dibit_count <= receive_dibit_count + 1'b1;
        end else begin
            receive_dibit_count <= '0;
        end
        byte_complete <= rmii_receive_data_enable && (receive_dibit_count == 2'd3);
        if (byte_complete) begin
            write_pointer <= write_pointer + 1'b1;
        end
        if (receive_data_enable) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end
end

// Least significant dibit arrives first
always_ff @(posedge clock) begin
    if (rmii_receive_data_enable) begin
        receive_shift <= {rmii_receive_data, receive_shift[7:2]};
    end
    // Carrier gone after the byte means it was the last one
    if (byte_complete) begin
        receive_que[write_pointer[switch_pkg::receive_que_address_width-1:0]] <=
            {!rmii_receive_data_enable, receive_shift};
    end
end

assign receive_data_valid = (write_pointer != read_pointer);
assign receive_data       = receive_que[read_pointer[switch_pkg::receive_que_address_width-1:0]];

//////////////////////////////////////////////////////////////////////
// Transmit holding byte and serializer
//////////////////////////////////////////////////////////////////////

logic [switch_pkg::port_data_width-1:0] hold_byte;
logic                                   hold_full;
logic [7:0]                             transmit_shift;
logic                                   transmit_last;
logic [1:0]                             transmit_dibit_count;
logic                                   transmit_active;
logic                                   load_shift;

// Chain bytes without a gap, except after the end of a frame
assign load_shift = hold_full &&
    (!transmit_active || (transmit_dibit_count == 2'd3 && !transmit_last));

always_ff @(posedge clock) begin
    if (reset) begin
        hold_full            <= 1'b0;
        transmit_active      <= 1'b0;
        transmit_dibit_count <= '0;
    end else begin
        if (transmit_data_enable) begin
            hold_full <= 1'b1;
        end else if (load_shift) begin
            hold_full <= 1'b0;
        end
        if (load_shift) begin
            transmit_active      <= 1'b1;
            transmit_dibit_count <= '0;
        end else if (transmit_active) begin
            transmit_dibit_count <= transmit_dibit_count + 1'b1;
            if (transmit_dibit_count == 2'd3) begin
                transmit_active <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clock) begin
    if (transmit_data_enable) begin
        hold_byte <= transmit_data;
    end
    if (load_shift) begin
        transmit_shift <= hold_byte[7:0];
        transmit_last  <= hold_byte[switch_pkg::port_data_width-1];
    end else if (transmit_active) begin
        transmit_shift <= {2'b00, transmit_shift[7:2]};
    end
end

assign transmit_ready           = !hold_full;
assign rmii_transmit_data       = transmit_shift[1:0];
assign rmii_transmit_data_valid = transmit_active;

endmodule

//--- hw/mac_table.sv
module mac_table (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    write_enable,
    input  logic [switch_pkg::port_index_width-1:0] write_address,
    input  logic [switch_pkg::mac_width-1:0]        write_data,
    input  logic [switch_pkg::port_index_width-1:0] read_address,

    output logic [switch_pkg::mac_width-1:0]        read_data,
    output logic                                    read_valid
);

logic [switch_pkg::mac_width-1:0]       entries [switch_pkg::number_of_ports];
logic [switch_pkg::number_of_ports-1:0] entry_valid;

always_ff @(posedge clock) begin
    if (reset) begin
        entry_valid <= '0;
        read_valid  <= 1'b0;
    end else begin
        if (write_enable) begin
            entry_valid[write_address] <= 1'b1;
        end
        read_valid <= entry_valid[read_address];
    end
end

// A new address replaces the old entry of its port
always_ff @(posedge clock) begin
    if (write_enable) begin
        entries[write_address] <= write_data;
    end
    read_data <= entries[read_address];
end

endmodule

//--- hw/core_data_orchestrator.sv
module core_data_orchestrator (
    input  logic                                                                clock,
    input  logic                                                                reset,
    input  logic [switch_pkg::number_of_ports-1:0]                              port_receive_data_valid,
    input  logic [switch_pkg::number_of_ports-1:0][switch_pkg::port_data_width-1:0] port_receive_data,
    input  logic [switch_pkg::number_of_ports-1:0]                              port_transmit_ready,
    input  logic [switch_pkg::mac_width-1:0]                                    mac_read_data,
    input  logic                                                                mac_read_valid,

    output logic [switch_pkg::number_of_ports-1:0]                              port_receive_data_enable,
    output logic [switch_pkg::port_data_width-1:0]                              port_transmit_data,
    output logic [switch_pkg::number_of_ports-1:0]                              port_transmit_data_valid,
    output logic [switch_pkg::port_index_width-1:0]                             mac_read_address,
    output logic                                                                mac_write_enable,
    output logic [switch_pkg::port_index_width-1:0]                             mac_write_address,
    output logic [switch_pkg::mac_width-1:0]                                    mac_write_data
);

switch_pkg::orchestrator_state_t            state;
logic [switch_pkg::port_index_width-1:0]    current_port;
logic [switch_pkg::port_index_width-1:0]    next_port;
logic [switch_pkg::port_index_width-1:0]    candidate_port;
logic                                       port_found;
logic [3:0]                                 byte_count;
logic [2:0]                                 scan_index;
logic                                       match_valid;
logic [switch_pkg::port_index_width-1:0]    match_port;
logic [switch_pkg::number_of_ports-1:0]     port_select;
logic [switch_pkg::number_of_ports-1:0]     transmit_mask;
logic [switch_pkg::number_of_ports-1:0]     decided_mask;
logic [switch_pkg::header_bytes*8-1:0]      header_buffer;
logic [switch_pkg::mac_width-1:0]           destination;
logic [switch_pkg::port_data_width-1:0]     served_data;
logic                                       all_ready;
logic                                       header_pop;
logic                                       drain_pop;
logic                                       header_transfer;
logic                                       payload_transfer;

//////////////////////////////////////////////////////////////////////
// Round robin pick and forwarding mask
//////////////////////////////////////////////////////////////////////

// Search starts after the last served port, which is checked last
always_comb begin
    next_port      = current_port;
    candidate_port = current_port;
    port_found     = 1'b0;
    for (int offset = 1; offset <= switch_pkg::number_of_ports; offset++) begin
        candidate_port = current_port + offset[switch_pkg::port_index_width-1:0];
        if (!port_found && port_receive_data_valid[candidate_port]) begin
            next_port  = candidate_port;
            port_found = 1'b1;
        end
    end
end

always_comb begin
    port_select               = '0;
    port_select[current_port] = 1'b1;
end

always_comb begin
    decided_mask = '0;
    if (destination == switch_pkg::broadcast_mac || !match_valid) begin
        decided_mask = ~port_select;
    end else if (match_port != current_port) begin
        decided_mask[match_port] = 1'b1;
    end
end

assign destination = header_buffer[switch_pkg::header_bytes*8-1 -: switch_pkg::mac_width];
assign served_data = port_receive_data[current_port];
assign all_ready   = (port_transmit_ready & transmit_mask) == transmit_mask;

assign header_pop       = (state == switch_pkg::st_header) && port_receive_data_valid[current_port];
assign drain_pop        = (state == switch_pkg::st_drain) && port_receive_data_valid[current_port];
assign header_transfer  = (state == switch_pkg::st_send_header) && all_ready;
assign payload_transfer = (state == switch_pkg::st_send_payload) &&
                          port_receive_data_valid[current_port] && all_ready;

//////////////////////////////////////////////////////////////////////
// Control FSM
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clock) begin
    if (reset) begin
        state         <= switch_pkg::st_idle;
        current_port  <= '0;
        byte_count    <= '0;
        scan_index    <= '0;
        match_valid   <= 1'b0;
        match_port    <= '0;
        transmit_mask <= '0;
    end else begin
        case (state)
            switch_pkg::st_idle: begin
                if (port_found) begin
                    current_port <= next_port;
                    byte_count   <= '0;
                    state        <= switch_pkg::st_header;
                end
            end
            switch_pkg::st_header: begin
                if (header_pop) begin
                    byte_count <= byte_count + 1'b1;
                    if (byte_count == switch_pkg::header_bytes - 1) begin
                        state <= switch_pkg::st_learn;
                    end
                end
            end
            switch_pkg::st_learn: begin
                scan_index  <= '0;
                match_valid <= 1'b0;
                state       <= switch_pkg::st_lookup;
            end
            // Read data trails the address by one cycle
            switch_pkg::st_lookup: begin
                if (scan_index != 3'd0 && mac_read_valid && !match_valid &&
                    mac_read_data == destination) begin
                    match_valid <= 1'b1;
                    match_port  <= scan_index[switch_pkg::port_index_width-1:0] - 1'b1;
                end
                if (scan_index == 3'd4) begin
                    state <= switch_pkg::st_decide;
                end else begin
                    scan_index <= scan_index + 1'b1;
                end
            end
            switch_pkg::st_decide: begin
                transmit_mask <= decided_mask;
                byte_count    <= '0;
                state         <= (decided_mask == '0) ? switch_pkg::st_drain
                                                      : switch_pkg::st_send_header;
            end
            switch_pkg::st_send_header: begin
                if (header_transfer) begin
                    byte_count <= byte_count + 1'b1;
                    if (byte_count == switch_pkg::header_bytes - 1) begin
                        state <= switch_pkg::st_send_payload;
                    end
                end
            end
            switch_pkg::st_send_payload: begin
                if (payload_transfer && served_data[switch_pkg::port_data_width-1]) begin
                    transmit_mask <= '0;
                    state         <= switch_pkg::st_idle;
                end
            end
            switch_pkg::st_drain: begin
                if (drain_pop && served_data[switch_pkg::port_data_width-1]) begin
                    state <= switch_pkg::st_idle;
                end
            end
            default: state <= switch_pkg::st_idle;
        endcase
    end
end

// Header enters and leaves most significant byte first
always_ff @(posedge clock) begin
    if (header_pop) begin
        header_buffer <= {header_buffer[switch_pkg::header_bytes*8-9:0], served_data[7:0]};
    end else if (header_transfer) begin
        header_buffer <= header_buffer << 8;
    end
end

//////////////////////////////////////////////////////////////////////
// Outputs
//////////////////////////////////////////////////////////////////////

assign port_receive_data_enable = (header_pop || payload_transfer || drain_pop) ? port_select
                                                                                 : '0;
assign port_transmit_data       = (state == switch_pkg::st_send_header) ?
                                  {1'b0, header_buffer[switch_pkg::header_bytes*8-1 -: 8]} :
                                  served_data;
assign port_transmit_data_valid = (header_transfer || payload_transfer) ? transmit_mask : '0;

assign mac_read_address  = scan_index[switch_pkg::port_index_width-1:0];
assign mac_write_enable  = (state == switch_pkg::st_learn);
assign mac_write_address = current_port;
assign mac_write_data    = header_buffer[switch_pkg::mac_width-1:0];

endmodule

//--- hw/switch_core.sv
module switch_core (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic [switch_pkg::number_of_ports-1:0][1:0] rmii_phy_receive_data,
    input  logic [switch_pkg::number_of_ports-1:0]      rmii_phy_receive_data_enable,

    output logic [switch_pkg::number_of_ports-1:0][1:0] rmii_phy_transmit_data,
    output logic [switch_pkg::number_of_ports-1:0]      rmii_phy_transmit_data_valid
);

logic [switch_pkg::number_of_ports-1:0]                                 port_receive_data_enable;
logic [switch_pkg::number_of_ports-1:0][switch_pkg::port_data_width-1:0] port_receive_data;
logic [switch_pkg::number_of_ports-1:0]                                 port_receive_data_valid;
logic [switch_pkg::number_of_ports-1:0]                                 port_transmit_ready;
logic [switch_pkg::port_data_width-1:0]                                 port_transmit_data;
logic [switch_pkg::number_of_ports-1:0]                                 port_transmit_data_valid;
logic [switch_pkg::mac_width-1:0]                                       mac_read_data;
logic                                                                   mac_read_valid;
logic [switch_pkg::port_index_width-1:0]                                mac_read_address;
logic                                                                   mac_write_enable;
logic [switch_pkg::port_index_width-1:0]                                mac_write_address;
logic [switch_pkg::mac_width-1:0]                                       mac_write_data;

for (genvar i = 0; i < switch_pkg::number_of_ports; i++) begin : g_port
    rmii_port u_rmii_port (
        .clock                    (clock),
        .reset                    (reset),
        .rmii_receive_data        (rmii_phy_receive_data[i]),
        .rmii_receive_data_enable (rmii_phy_receive_data_enable[i]),
        .receive_data_enable      (port_receive_data_enable[i]),
        .transmit_data            (port_transmit_data),
        .transmit_data_enable     (port_transmit_data_valid[i]),
        .receive_data             (port_receive_data[i]),
        .receive_data_valid       (port_receive_data_valid[i]),
        .transmit_ready           (port_transmit_ready[i]),
        .rmii_transmit_data       (rmii_phy_transmit_data[i]),
        .rmii_transmit_data_valid (rmii_phy_transmit_data_valid[i])
    );
end

core_data_orchestrator u_core_data_orchestrator (
    .clock                    (clock),
    .reset                    (reset),
    .port_receive_data_valid  (port_receive_data_valid),
    .port_receive_data        (port_receive_data),
    .port_transmit_ready      (port_transmit_ready),
    .mac_read_data            (mac_read_data),
    .mac_read_valid           (mac_read_valid),
    .port_receive_data_enable (port_receive_data_enable),
    .port_transmit_data       (port_transmit_data),
    .port_transmit_data_valid (port_transmit_data_valid),
    .mac_read_address         (mac_read_address),
    .mac_write_enable         (mac_write_enable),
    .mac_write_address        (mac_write_address),
    .mac_write_data           (mac_write_data)
);

mac_table u_mac_table (
    .clock         (clock),
    .reset         (reset),
    .write_enable  (mac_write_enable),
    .write_address (mac_write_address),
    .write_data    (mac_write_data),
    .read_address  (mac_read_address),
    .read_data     (mac_read_data),
    .read_valid    (mac_read_valid)
);

endmodule

//--- tests/switch_core_props.sv
module switch_core_props (
    input logic                                    clock,
    input logic                                    reset,
    input switch_pkg::orchestrator_state_t         state,
    input logic [switch_pkg::port_index_width-1:0] current_port,
    input logic [switch_pkg::number_of_ports-1:0]  port_receive_data_valid,
    input logic [switch_pkg::number_of_ports-1:0]  port_receive_data_enable,
    input logic [switch_pkg::number_of_ports-1:0]  port_transmit_data_valid,
    input logic                                    mac_write_enable
);

// Pops go to one port at a time
enable_one_hot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(port_receive_data_enable))
    else $error("receive enable raised on more than one port");

enable_needs_valid: assert property (@(posedge clock) disable iff (reset)
    (port_receive_data_enable & ~port_receive_data_valid) == '0)
    else $error("receive enable raised on a port without valid data");

enable_in_pop_states: assert property (@(posedge clock) disable iff (reset)
    port_receive_data_enable != '0 |-> state inside {switch_pkg::st_header,
        switch_pkg::st_send_payload, switch_pkg::st_drain})
    else $error("receive enable raised outside a popping state");

// A frame never returns to the port it came from
mask_excludes_source: assert property (@(posedge clock) disable iff (reset)
    !port_transmit_data_valid[current_port])
    else $error("transmit mask includes the port being served");

quiet_after_reset: assert property (@(posedge clock)
    reset |=> (port_receive_data_enable == '0 && port_transmit_data_valid == '0 &&
               !mac_write_enable))
    else $error("orchestrator outputs active during reset");

endmodule

bind core_data_orchestrator switch_core_props u_switch_core_props (
    .clock                    (clock),
    .reset                    (reset),
    .state                    (state),
    .current_port             (current_port),
    .port_receive_data_valid  (port_receive_data_valid),
    .port_receive_data_enable (port_receive_data_enable),
    .port_transmit_data_valid (port_transmit_data_valid),
    .mac_write_enable         (mac_write_enable)
);

//--- tests/switch_core_tb.sv
module switch_core_tb;

logic                                        clock;
logic                                        reset;
logic [switch_pkg::number_of_ports-1:0][1:0] rmii_phy_receive_data;
logic [switch_pkg::number_of_ports-1:0]      rmii_phy_receive_data_enable;
logic [switch_pkg::number_of_ports-1:0][1:0] rmii_phy_transmit_data;
logic [switch_pkg::number_of_ports-1:0]      rmii_phy_transmit_data_valid;

// Records hold id, paired flag, port, mask, length and bytes
logic [7:0]                             vectors [512];
int                                     expected_record [switch_pkg::number_of_ports][32];
int                                     expected_head [switch_pkg::number_of_ports];
int                                     expected_tail [switch_pkg::number_of_ports];
logic [7:0]                             received_bytes [switch_pkg::number_of_ports][64];
int                                     received_count [switch_pkg::number_of_ports];
int                                     received_dibits [switch_pkg::number_of_ports];
logic [7:0]                             received_shift [switch_pkg::number_of_ports];
logic [switch_pkg::number_of_ports-1:0] valid_before;
int                                     cycle_count;
int                                     cycle_limit;

switch_core u_dut (
    .clock                        (clock),
    .reset                        (reset),
    .rmii_phy_receive_data        (rmii_phy_receive_data),
    .rmii_phy_receive_data_enable (rmii_phy_receive_data_enable),
    .rmii_phy_transmit_data       (rmii_phy_transmit_data),
    .rmii_phy_transmit_data_valid (rmii_phy_transmit_data_valid)
);

initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
end

//////////////////////////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////////////////////////

task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first failure");
endtask

function automatic string test_name(input logic [7:0] id);
    case (id)
        8'h01:   return "reset_then_unknown_flood";
        8'h02:   return "unknown_flood";
        8'h03:   return "learned_unicast";
        8'h04:   return "broadcast_flood";
        8'h05:   return "own_port_drop";
        8'h06:   return "concurrent_ports";
        default: return "unnamed_test";
    endcase
endfunction

task automatic expect_frame(input int record);
    logic [7:0] mask;
    mask = vectors[record + 3];
    for (int p = 0; p < switch_pkg::number_of_ports; p++) begin
        if (mask[p]) begin
            expected_record[p][expected_tail[p] % 32] = record;
            expected_tail[p] = expected_tail[p] + 1;
        end
    end
endtask

// Dibits go out least significant first
task automatic drive_frame(input int record);
    int         port;
    int         length;
    logic [7:0] frame_byte;
    port   = vectors[record + 2];
    length = vectors[record + 4];
    for (int i = 0; i < length; i++) begin
        frame_byte = vectors[record + 5 + i];
        for (int k = 0; k < 4; k++) begin
            @(posedge clock);
            rmii_phy_receive_data[port]        <= frame_byte[2*k +: 2];
            rmii_phy_receive_data_enable[port] <= 1'b1;
        end
    end
    @(posedge clock);
    rmii_phy_receive_data[port]        <= 2'b00;
    rmii_phy_receive_data_enable[port] <= 1'b0;
endtask

task automatic wait_for_delivery();
    int pending;
    do begin
        @(negedge clock);
        pending = 0;
        for (int p = 0; p < switch_pkg::number_of_ports; p++) begin
            pending = pending + expected_tail[p] - expected_head[p];
        end
    end while (pending != 0);
endtask

task automatic check_frame(input int port);
    int    record;
    int    length;
    string name;
    assert (expected_head[port] != expected_tail[port]) else begin
        $display("Port %0d sent a frame while no frame was expected there", port);
        stop_with_failure();
    end
    record = expected_record[port][expected_head[port] % 32];
    expected_head[port] = expected_head[port] + 1;
    length = vectors[record + 4];
    name   = test_name(vectors[record]);
    assert (received_dibits[port] % 4 == 0) else begin
        $display("Port %0d ended a frame in the middle of a byte", port);
        stop_with_failure();
    end
    assert (received_count[port] == length) else begin
        $display("ERROR %s port %0d length: expected %0d, actual %0d",
                 name, port, length, received_count[port]);
        stop_with_failure();
    end
    for (int i = 0; i < length; i++) begin
        assert (received_bytes[port][i] === vectors[record + 5 + i]) else begin
            $display("ERROR %s port %0d byte %0d: expected %02h, actual %02h",
                     name, port, i, vectors[record + 5 + i], received_bytes[port][i]);
            stop_with_failure();
        end
    end
endtask

//////////////////////////////////////////////////////////////////////
// Output monitors and cycle limit
//////////////////////////////////////////////////////////////////////

always @(posedge clock) begin
    for (int p = 0; p < switch_pkg::number_of_ports; p++) begin
        if (rmii_phy_transmit_data_valid[p] === 1'b1) begin
            received_shift[p]  = {rmii_phy_transmit_data[p], received_shift[p][7:2]};
            received_dibits[p] = received_dibits[p] + 1;
            if (received_dibits[p] % 4 == 0) begin
                if (received_count[p] < 64) begin
                    received_bytes[p][received_count[p]] = received_shift[p];
                end
                received_count[p] = received_count[p] + 1;
            end
        end else if (valid_before[p] === 1'b1) begin
            // Valid falling marks the end of a frame
            check_frame(p);
            received_count[p]  = 0;
            received_dibits[p] = 0;
        end
        valid_before[p] = rmii_phy_transmit_data_valid[p];
    end
end

always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
        $display("Run went past %0d cycles without delivering every frame", cycle_limit);
        stop_with_failure();
    end
end

//////////////////////////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////////////////////////

initial begin
    int record;
    int next_record;
    int gap;
    int total_bytes;
    void'($urandom(32'h13ab_518a));
    cycle_count = 0;
    $readmemh("tests/switch_vectors.txt", vectors);
    total_bytes = 0;
    record      = 0;
    while (vectors[record] != 8'hff) begin
        total_bytes = total_bytes + vectors[record + 4];
        record      = record + 5 + vectors[record + 4];
    end
    cycle_limit = 40 * 4 * total_bytes + 2000;

    reset                        = 1'b1;
    rmii_phy_receive_data        = '0;
    rmii_phy_receive_data_enable = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    // Nothing may leave the switch before the first frame
    repeat (20) begin
        @(negedge clock);
        assert (rmii_phy_transmit_data_valid == '0) else begin
            $display("Transmit valid rose after reset with no frame sent");
            stop_with_failure();
        end
    end

    record = 0;
    while (vectors[record] != 8'hff) begin
        next_record = record + 5 + vectors[record + 4];
        gap         = 1 + ($urandom % 16);
        expect_frame(record);
        repeat (gap) @(posedge clock);
        if (vectors[record + 1] == 8'h01) begin
            expect_frame(next_record);
            fork
                drive_frame(record);
                drive_frame(next_record);
            join
            record = next_record + 5 + vectors[next_record + 4];
        end else begin
            drive_frame(record);
            record = next_record;
        end
        wait_for_delivery();
    end

    repeat (200) begin
        @(negedge clock);
        assert (rmii_phy_transmit_data_valid == '0) else begin
            $display("Transmit valid rose after every expected frame was delivered");
            stop_with_failure();
        end
    end
    $display("TEST PASS");
    $finish;
end

endmodule

//--- list.f
hw/switch_pkg.sv
hw/rmii_port.sv
hw/mac_table.sv
hw/core_data_orchestrator.sv
hw/switch_core.sv
tests/switch_core_props.sv
tests/switch_core_tb.sv

//--- Bender.yml
package:
  name: switch_core

sources:
  - files:
      - hw/switch_pkg.sv
      - hw/rmii_port.sv
      - hw/mac_table.sv
      - hw/core_data_orchestrator.sv
      - hw/switch_core.sv
  - target: test
    files:
      - tests/switch_core_props.sv
      - tests/switch_core_tb.sv

//--- tests/switch_vectors.txt
// test id, drive with next record (01), source port, expected output mask, byte count, bytes
// Hosts: A 0a on port 2, B 0b on port 1, C 0c on port 0, D 0d on port 3, ee unknown
01 00 02 0b 10 02 00 00 00 00 ee 02 00 00 00 00 0a 11 22 33 44
02 00 01 0d 12 02 00 00 00 00 ee 02 00 00 00 00 0b 51 52 53 54 55 56
03 00 00 04 10 02 00 00 00 00 0a 02 00 00 00 00 0c a0 a1 a2 a3
04 00 03 07 14 ff ff ff ff ff ff 02 00 00 00 00 0d 00 ff 01 fe 02 fd 03 fc
// Destination on its own port, then a normal frame
05 00 01 00 10 02 00 00 00 00 0b 02 00 00 00 00 0b 5a 5b 5c 5d
05 00 03 02 0e 02 00 00 00 00 0b 02 00 00 00 00 0d 77 88
// Two ports at once
06 01 00 04 18 02 00 00 00 00 0a 02 00 00 00 00 0c c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb
06 00 01 08 16 02 00 00 00 00 0d 02 00 00 00 00 0b d0 d1 d2 d3 d4 d5 d6 d7 d8 d9
06 00 02 01 10 02 00 00 00 00 0c 02 00 00 00 00 0a e0 e1 e2 e3
ff
